// File: src/uvc_defs.svh
// uvc application constants
`ifndef UVC_DEFS_SVH
`define UVC_DEFS_SVH

// ====================
// probe control block
`define UVC_PROBE_LEN          34
`define UVC_DEF_FRAME_INTERVAL 333333      // 100 ns units, 30 fps
`define UVC_DEF_MAX_FRAME_SIZE 614400      // 640x480 yuy2
`define UVC_DEF_CLOCK_FREQ     60000000
`define UVC_VS_INTERFACE       1
`define UVC_VS_PROBE_CONTROL   1

// ====================
// streaming side
`define UVC_PAYLOAD_SIZE       1024        // bytes per iso packet
`define UVC_ISO_ENDPT          2
`define UVC_FIFO_DEPTH         2048
`define UVC_FIFO_AFULL         1024        // enough for a full packet
`define UVC_FIFO_AEMPTY        512

// interfaces with an alternate setting
`define UVC_NUM_INF            2

`endif

// File: src/usb_pkg.sv
// usb protocol types
package usb_pkg;

   // data pids, high bandwidth iso uses all three
   typedef enum logic [3:0] {
      PID_DATA0 = 4'b0011,
      PID_DATA1 = 4'b1011,
      PID_DATA2 = 4'b0111
   } usb_pid_e;

   // video class request codes
   typedef enum logic [7:0] {
      SET_CUR = 8'h01,
      GET_CUR = 8'h81,
      GET_DEF = 8'h87
   } req_code_e;

   typedef logic [3:0] endpt_t;   // endpoint number

endpackage

// File: src/uvc_pkg.sv
// video class types
`include "uvc_defs.svh"

package uvc_pkg;

   // byte offset into the probe block
   typedef logic [5:0] probe_idx_t;

   // probe block, element k is byte k on the wire
   typedef logic [`UVC_PROBE_LEN-1:0][7:0] probe_bytes_t;

   // fifo level, wide enough for a full fifo
   typedef logic [11:0] fifo_cnt_t;

endpackage

// File: src/ctrl_if.sv
// endpoint 0 control interfaces
`timescale 1ns/1ps

// request summary from the setup parser
interface ctrl_req_if;
   logic        setup_done;   // strobe after byte 8
   logic        probe_get;    // get_cur or get_def on the probe
   logic        probe_set;    // set_cur on the probe
   logic [15:0] w_length;

   modport src (output setup_done, probe_get, probe_set, w_length);
   modport dst (input  setup_done, probe_get, probe_set, w_length);
endinterface

// endpoint 0 data path, already gated by endpoint
interface ep0_if;
   logic       rx_strobe;
   logic       rx_act;
   logic [7:0] rxdat;
   logic       tx_act;
   logic       tx_pop;
   logic [7:0] txdat;
   logic       txval;

   modport router (output rx_strobe, rx_act, rxdat, tx_act, tx_pop,
                   input  txdat, txval);
   modport func   (input  rx_strobe, rx_act, rxdat, tx_act, tx_pop,
                   output txdat, txval);
endinterface

// File: src/setup_parser.sv
// setup packet parser
`timescale 1ns/1ps
`include "uvc_defs.svh"

module setup_parser
   import usb_pkg::*;
(
   input  logic       PHY_CLKOUT,
   input  logic       RESET_IN,
   input  logic       setup_i,
   input  logic       rxval_i,
   input  logic [7:0] rxdat_i,
   ctrl_req_if.src    req
);

   logic [2:0]  stage_q;         // setup byte counter
   req_code_e   b_request_q;
   logic [7:0]  w_value_hi_q;    // control selector
   logic [7:0]  w_index_lo_q;    // interface number
   logic [15:0] w_length_q;
   logic        done_q;
   logic        get_q;
   logic        set_q;
   logic        is_probe;

   assign is_probe = (w_index_lo_q == 8'(`UVC_VS_INTERFACE)) &&
                     (w_value_hi_q == 8'(`UVC_VS_PROBE_CONTROL));

   // request fields
   always_ff @(posedge PHY_CLKOUT) begin
      if (setup_i && rxval_i) begin
         case (stage_q)
            3'd1:    b_request_q      <= req_code_e'(rxdat_i);
            3'd3:    w_value_hi_q     <= rxdat_i;
            3'd4:    w_index_lo_q     <= rxdat_i;
            3'd6:    w_length_q[7:0]  <= rxdat_i;
            3'd7:    w_length_q[15:8] <= rxdat_i;
            default: ;                 // request type, wvalue lo, windex hi
         endcase
      end
   end

   always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
      if (RESET_IN) begin
         stage_q <= '0;
         done_q  <= 1'b0;
         get_q   <= 1'b0;
         set_q   <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (!setup_i) begin
            stage_q <= '0;
         end else if (rxval_i) begin
            stage_q <= stage_q + 3'd1;   // wraps after byte 8
            if (stage_q == 3'd0) begin
               get_q <= 1'b0;           // a new request drops the old one
               set_q <= 1'b0;
            end
            if (stage_q == 3'd7) begin
               done_q <= 1'b1;
               get_q  <= is_probe && ((b_request_q == GET_CUR) || (b_request_q == GET_DEF));
               set_q  <= is_probe && (b_request_q == SET_CUR);
            end
         end
      end
   end

   assign req.setup_done = done_q;
   assign req.probe_get  = get_q;
   assign req.probe_set  = set_q;
   assign req.w_length   = w_length_q;

endmodule

// File: src/video_ctrl_regs.sv
// video probe and interface registers
`timescale 1ns/1ps
`include "uvc_defs.svh"

module video_ctrl_regs
   import uvc_pkg::*;
(
   input  logic       PHY_CLKOUT,
   input  logic       RESET_IN,
   input  logic [7:0] inf_sel_i,
   input  logic [7:0] inf_alter_i,
   input  logic       inf_set_i,
   output logic [7:0] inf_alter_o,
   ctrl_req_if.dst    req,
   ep0_if.func        ep0
);

   localparam int PLEN = `UVC_PROBE_LEN;

   // power-up probe contents, multi-byte fields little endian
   function automatic probe_bytes_t probe_default();
      probe_bytes_t p;
      p        = '0;
      p[2]     = 8'd1;                          // format index
      p[3]     = 8'd1;                          // frame index
      p[7:4]   = 32'(`UVC_DEF_FRAME_INTERVAL);
      p[21:18] = 32'(`UVC_DEF_MAX_FRAME_SIZE);
      p[25:22] = 32'(`UVC_PAYLOAD_SIZE);
      p[29:26] = 32'(`UVC_DEF_CLOCK_FREQ);
      return p;
   endfunction

   localparam probe_bytes_t PROBE_DEF = probe_default();

   probe_bytes_t probe_q;
   probe_idx_t   wr_idx_q;
   probe_idx_t   rd_idx_q;
   probe_idx_t   rd_next;
   probe_idx_t   rd_last;     // final byte of the read-back
   logic         wr_armed_q;  // data stage of a probe set_cur pending
   logic         wr_keep;
   logic [7:0]   txdat_q;
   logic         txval_q;
   logic [7:0]   alt_q [`UVC_NUM_INF];

   // max payload size is fixed by the iso endpoint
   assign wr_keep = (wr_idx_q >= probe_idx_t'(22)) && (wr_idx_q <= probe_idx_t'(25));
   assign rd_next = rd_idx_q + probe_idx_t'(ep0.tx_pop);
   assign rd_last = (req.w_length < 16'(PLEN)) ? probe_idx_t'(req.w_length - 16'd1)
                                                : probe_idx_t'(PLEN - 1);

   // ====================
   // set_cur write side
   always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
      if (RESET_IN) begin
         probe_q    <= PROBE_DEF;
         wr_idx_q   <= '0;
         wr_armed_q <= 1'b0;
      end else begin
         if (req.setup_done) begin
            wr_armed_q <= req.probe_set;
         end else if (!ep0.rx_act && (wr_idx_q != '0)) begin
            wr_armed_q <= 1'b0;          // data packet finished
         end
         if (!ep0.rx_act) begin
            wr_idx_q <= '0;
         end else if (ep0.rx_strobe && req.probe_set && wr_armed_q) begin
            if (wr_idx_q < probe_idx_t'(PLEN)) begin
               if (!wr_keep) begin
                  probe_q[wr_idx_q] <= ep0.rxdat;
               end
               wr_idx_q <= wr_idx_q + probe_idx_t'(1);
            end
         end
      end
   end

   // ====================
   // get_cur read side
   always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
      if (RESET_IN) begin
         rd_idx_q <= '0;
         txval_q  <= 1'b0;
      end else if (req.setup_done) begin
         rd_idx_q <= '0;
         txval_q  <= req.probe_get && (req.w_length != '0);
      end else if (ep0.tx_act && txval_q && ep0.tx_pop) begin
         rd_idx_q <= rd_next;
         if (rd_idx_q == rd_last) begin
            txval_q <= 1'b0;             // last byte taken
         end
      end
   end

   // byte under the read index, one cycle behind a pop
   always_ff @(posedge PHY_CLKOUT) begin
      if (ep0.tx_act && txval_q) begin
         txdat_q <= (rd_next < probe_idx_t'(PLEN)) ? probe_q[rd_next] : 8'h00;
      end
   end

   assign ep0.txdat = txdat_q;
   assign ep0.txval = txval_q;

   // ====================
   // alternate settings
   always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
      if (RESET_IN) begin
         for (int i = 0; i < `UVC_NUM_INF; i++) begin
            alt_q[i] <= '0;
         end
      end else if (inf_set_i) begin
         for (int i = 0; i < `UVC_NUM_INF; i++) begin
            if (inf_sel_i == 8'(i)) begin
               alt_q[i] <= inf_alter_i;
            end
         end
      end
   end

   always_comb begin
      inf_alter_o = '0;                  // unknown interface reads 0
      for (int i = 0; i < `UVC_NUM_INF; i++) begin
         if (inf_sel_i == 8'(i)) begin
            inf_alter_o = alt_q[i];
         end
      end
   end

endmodule

// File: src/endpoint_router.sv
// endpoint decode and data routing
`timescale 1ns/1ps
`include "uvc_defs.svh"

module endpoint_router
   import usb_pkg::*;
(
   input  logic       PHY_CLKOUT,
   input  logic       RESET_IN,
   input  endpt_t     endpt_i,
   input  logic [7:0] rxdat_i,
   input  logic       rxval_i,
   input  logic       rxact_i,
   input  logic       txact_i,
   input  logic       txpop_i,
   input  logic [7:0] fifo_rdat_i,
   output logic       fifo_pop_o,
   output logic [7:0] txdat_o,
   output logic       txval_o,
   output logic       is_ep0_o,
   output logic       is_iso_o,
   output logic       iso_done_o,
   ep0_if.router      ep0
);

   logic txact_d_q;

   assign is_ep0_o = (endpt_i == '0);
   assign is_iso_o = (endpt_i == endpt_t'(`UVC_ISO_ENDPT));

   // control endpoint strobes
   assign ep0.rx_act    = rxact_i && is_ep0_o;
   assign ep0.rx_strobe = rxval_i && rxact_i && is_ep0_o;
   assign ep0.rxdat     = rxdat_i;
   assign ep0.tx_act    = txact_i && is_ep0_o;
   assign ep0.tx_pop    = txpop_i && txact_i && is_ep0_o;

   assign fifo_pop_o = txact_i && txpop_i && is_iso_o;   // video stream
   assign txdat_o    = is_ep0_o ? ep0.txdat : fifo_rdat_i;
   assign txval_o    = is_ep0_o && ep0.txval;

   always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
      if (RESET_IN) begin
         txact_d_q <= 1'b0;
      end else begin
         txact_d_q <= txact_i;
      end
   end

   // end of an iso transfer
   assign iso_done_o = txact_d_q && !txact_i && is_iso_o;

endmodule

// File: src/iso_payload_ctrl.sv
// iso payload length, cork and pid
`timescale 1ns/1ps
`include "uvc_defs.svh"

module iso_payload_ctrl
   import usb_pkg::*;
   import uvc_pkg::*;
(
   input  logic      PHY_CLKOUT,
   input  logic      RESET_IN,
   input  logic      txact_i,
   input  logic      is_ep0_i,
   input  logic      is_iso_i,
   input  logic      iso_done_i,
   input  logic      sof_i,
   input  logic      frame_dval_i,
   input  fifo_cnt_t fifo_cnt_i,
   input  logic      fifo_afull_i,
   input  logic      fifo_aempty_i,
   input  logic      fifo_empty_i,
   output fifo_cnt_t txdat_len_o,
   output logic      txcork_o,
   output usb_pid_e  txiso_pid_o
);

   // ====================
   // next packet size, held while a transfer runs
   always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
      if (RESET_IN) begin
         txdat_len_o <= fifo_cnt_t'(`UVC_PROBE_LEN);
         txcork_o    <= 1'b0;
      end else if (!txact_i) begin
         if (is_ep0_i) begin
            txdat_len_o <= fifo_cnt_t'(`UVC_PROBE_LEN);
            txcork_o    <= 1'b0;
         end else if (is_iso_i) begin
            if (fifo_afull_i) begin
               txdat_len_o <= fifo_cnt_t'(`UVC_PAYLOAD_SIZE);
               txcork_o    <= 1'b0;
            end else if (frame_dval_i || fifo_empty_i) begin
               // wait while the line is still being written
               txdat_len_o <= '0;
               txcork_o    <= 1'b1;
            end else if (fifo_aempty_i) begin
               txdat_len_o <= fifo_cnt_i;          // short packet, drain
               txcork_o    <= 1'b0;
            end else begin
               txdat_len_o <= fifo_cnt_t'(`UVC_PAYLOAD_SIZE);
               txcork_o    <= 1'b0;
            end
         end else begin
            txdat_len_o <= '0;                    // nothing to send
            txcork_o    <= 1'b1;
         end
      end
   end

   // ====================
   // high bandwidth pid, three packets per microframe
   always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
      if (RESET_IN) begin
         txiso_pid_o <= PID_DATA2;
      end else if (sof_i) begin
         if (fifo_afull_i) begin
            txiso_pid_o <= PID_DATA2;             // three packets
         end else if (fifo_aempty_i) begin
            txiso_pid_o <= PID_DATA0;             // one packet
         end else begin
            txiso_pid_o <= PID_DATA1;
         end
      end else if (iso_done_i) begin
         case (txiso_pid_o)
            PID_DATA2: txiso_pid_o <= PID_DATA1;
            PID_DATA1: txiso_pid_o <= PID_DATA0;
            default:   txiso_pid_o <= PID_DATA0;  // last of the microframe
         endcase
      end
   end

endmodule

// File: src/frame_fifo.sv
// frame byte fifo
`timescale 1ns/1ps
`include "uvc_defs.svh"

module frame_fifo
   import uvc_pkg::*;
#(
   parameter int DEPTH = `UVC_FIFO_DEPTH
) (
   input  logic       PHY_CLKOUT,
   input  logic       RESET_IN,
   input  logic       push_i,
   input  logic [7:0] din_i,
   input  logic       pop_i,
   output logic [7:0] dout_o,
   output fifo_cnt_t  cnt_o,
   output logic       afull_o,
   output logic       aempty_o,
   output logic       empty_o
);

   localparam int AW = $clog2(DEPTH);

   logic [7:0]    mem [DEPTH];
   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   fifo_cnt_t     cnt_q;
   logic          do_push;
   logic          do_pop;

   assign do_push = push_i && (cnt_q < fifo_cnt_t'(DEPTH));   // drop when full
   assign do_pop  = pop_i && (cnt_q != '0);

   always_ff @(posedge PHY_CLKOUT or posedge RESET_IN) begin
      if (RESET_IN) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   cnt_q <= cnt_q + 1'b1;
            2'b01:   cnt_q <= cnt_q - 1'b1;
            default: ;                    // both or neither
         endcase
      end
   end

   // storage and registered read port
   always_ff @(posedge PHY_CLKOUT) begin
      if (do_push) begin
         mem[wr_ptr_q] <= din_i;
      end
      if (do_pop) begin
         dout_o <= mem[rd_ptr_q];
      end
   end

   assign cnt_o    = cnt_q;
   assign afull_o  = (cnt_q >= fifo_cnt_t'(`UVC_FIFO_AFULL));
   assign aempty_o = (cnt_q <= fifo_cnt_t'(`UVC_FIFO_AEMPTY));
   assign empty_o  = (cnt_q == '0);

endmodule

// File: src/uvc_app_top.sv
// uvc application layer top
`timescale 1ns/1ps
`include "uvc_defs.svh"

module uvc_app_top
   import usb_pkg::*;
   import uvc_pkg::*;
(
   input  logic       PHY_CLKOUT,
   input  logic       RESET_IN,
   input  logic       setup_i,
   input  endpt_t     endpt_i,
   input  logic [7:0] rxdat_i,
   input  logic       rxval_i,
   input  logic       rxact_i,
   input  logic       txact_i,
   input  logic       txpop_i,
   input  logic       sof_i,
   input  logic [7:0] inf_sel_i,
   input  logic [7:0] inf_alter_i,
   input  logic       inf_set_i,
   input  logic [7:0] frame_data_i,
   input  logic       frame_dval_i,
   output logic [7:0] txdat_o,
   output logic       txval_o,
   output fifo_cnt_t  txdat_len_o,
   output logic       txcork_o,
   output usb_pid_e   txiso_pid_o,
   output logic [7:0] inf_alter_o
);

   ctrl_req_if u_req_if ();
   ep0_if      u_ep0_if ();

   logic       fifo_pop;
   logic [7:0] fifo_rdat;
   fifo_cnt_t  fifo_cnt;
   logic       fifo_afull;
   logic       fifo_aempty;
   logic       fifo_empty;
   logic       is_ep0;
   logic       is_iso;
   logic       iso_done;

   // ====================
   // endpoint 0 control
   setup_parser u_setup_parser (
      .PHY_CLKOUT (PHY_CLKOUT),
      .RESET_IN   (RESET_IN),
      .setup_i    (setup_i),
      .rxval_i    (rxval_i),
      .rxdat_i    (rxdat_i),
      .req        (u_req_if.src)
   );

   video_ctrl_regs u_video_ctrl_regs (
      .PHY_CLKOUT  (PHY_CLKOUT),
      .RESET_IN    (RESET_IN),
      .inf_sel_i   (inf_sel_i),
      .inf_alter_i (inf_alter_i),
      .inf_set_i   (inf_set_i),
      .inf_alter_o (inf_alter_o),
      .req         (u_req_if.dst),
      .ep0         (u_ep0_if.func)
   );

   endpoint_router u_endpoint_router (
      .PHY_CLKOUT  (PHY_CLKOUT),
      .RESET_IN    (RESET_IN),
      .endpt_i     (endpt_i),
      .rxdat_i     (rxdat_i),
      .rxval_i     (rxval_i),
      .rxact_i     (rxact_i),
      .txact_i     (txact_i),
      .txpop_i     (txpop_i),
      .fifo_rdat_i (fifo_rdat),
      .fifo_pop_o  (fifo_pop),
      .txdat_o     (txdat_o),
      .txval_o     (txval_o),
      .is_ep0_o    (is_ep0),
      .is_iso_o    (is_iso),
      .iso_done_o  (iso_done),
      .ep0         (u_ep0_if.router)
   );

   // ====================
   // video stream
   iso_payload_ctrl u_iso_payload_ctrl (
      .PHY_CLKOUT    (PHY_CLKOUT),
      .RESET_IN      (RESET_IN),
      .txact_i       (txact_i),
      .is_ep0_i      (is_ep0),
      .is_iso_i      (is_iso),
      .iso_done_i    (iso_done),
      .sof_i         (sof_i),
      .frame_dval_i  (frame_dval_i),
      .fifo_cnt_i    (fifo_cnt),
      .fifo_afull_i  (fifo_afull),
      .fifo_aempty_i (fifo_aempty),
      .fifo_empty_i  (fifo_empty),
      .txdat_len_o   (txdat_len_o),
      .txcork_o      (txcork_o),
      .txiso_pid_o   (txiso_pid_o)
   );

   frame_fifo #(
      .DEPTH (`UVC_FIFO_DEPTH)
   ) u_frame_fifo (
      .PHY_CLKOUT (PHY_CLKOUT),
      .RESET_IN   (RESET_IN),
      .push_i     (frame_dval_i),
      .din_i      (frame_data_i),
      .pop_i      (fifo_pop),
      .dout_o     (fifo_rdat),
      .cnt_o      (fifo_cnt),
      .afull_o    (fifo_afull),
      .aempty_o   (fifo_aempty),
      .empty_o    (fifo_empty)
   );

endmodule

// File: sim/tb_uvc_app.sv
// uvc application testbench
`timescale 1ns/1ps
`include "uvc_defs.svh"

module tb_uvc_app
   import usb_pkg::*;
   import uvc_pkg::*;
();

   localparam int PLEN    = `UVC_PROBE_LEN;
   localparam int HALF    = 20;            // 40 ns period
   localparam int TIMEOUT = 200;           // cycles per wait

   logic       PHY_CLKOUT;
   logic       RESET_IN;
   logic       setup_i;
   endpt_t     endpt_i;
   logic [7:0] rxdat_i;
   logic       rxval_i;
   logic       rxact_i;
   logic       txact_i;
   logic       txpop_i;
   logic       sof_i;
   logic [7:0] inf_sel_i;
   logic [7:0] inf_alter_i;
   logic       inf_set_i;
   logic [7:0] frame_data_i;
   logic       frame_dval_i;
   logic [7:0] txdat_o;
   logic       txval_o;
   fifo_cnt_t  txdat_len_o;
   logic       txcork_o;
   usb_pid_e   txiso_pid_o;
   logic [7:0] inf_alter_o;

   // payload sizing rows of endpoint, fifo level, expected length and cork
   typedef struct packed {
      int endpt;
      int level;
      int len;
      int cork;
   } size_row_t;

   size_row_t size_tab [8] = '{
      '{2, 0,    0,                   1},   // empty fifo corks
      '{2, 100,  100,                 0},
      '{2, 512,  512,                 0},   // at the almost-empty level
      '{2, 700,  `UVC_PAYLOAD_SIZE,   0},
      '{2, 1024, `UVC_PAYLOAD_SIZE,   0},
      '{2, 1500, `UVC_PAYLOAD_SIZE,   0},
      '{0, 1500, `UVC_PROBE_LEN,      0},
      '{5, 1500, 0,                   1}
   };

   int          errors;
   int          checks;
   int          wr_count;                 // bytes pushed into the fifo
   int          rd_count;                 // bytes popped from the fifo
   logic [31:0] rnd;
   logic [7:0]  exp_probe [PLEN];

   uvc_app_top u_dut (
      .PHY_CLKOUT   (PHY_CLKOUT),
      .RESET_IN     (RESET_IN),
      .setup_i      (setup_i),
      .endpt_i      (endpt_i),
      .rxdat_i      (rxdat_i),
      .rxval_i      (rxval_i),
      .rxact_i      (rxact_i),
      .txact_i      (txact_i),
      .txpop_i      (txpop_i),
      .sof_i        (sof_i),
      .inf_sel_i    (inf_sel_i),
      .inf_alter_i  (inf_alter_i),
      .inf_set_i    (inf_set_i),
      .frame_data_i (frame_data_i),
      .frame_dval_i (frame_dval_i),
      .txdat_o      (txdat_o),
      .txval_o      (txval_o),
      .txdat_len_o  (txdat_len_o),
      .txcork_o     (txcork_o),
      .txiso_pid_o  (txiso_pid_o),
      .inf_alter_o  (inf_alter_o)
   );

   initial begin
      PHY_CLKOUT = 1'b0;
      forever #HALF PHY_CLKOUT = ~PHY_CLKOUT;
   end

   // ====================
   // helpers
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [7:0] fill_byte(input int n);
      return 8'(n ^ (n >> 8) ^ 8'h5a);     // all address bits matter
   endfunction

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic put_le32(input int at, input logic [31:0] v);
      for (int i = 0; i < 4; i++) begin
         exp_probe[at+i] = v[8*i +: 8];
      end
   endtask

   task automatic wait_txval();
      int n;
      n = 0;
      while (!txval_o && n < TIMEOUT) begin
         @(negedge PHY_CLKOUT);
         n++;
      end
      if (!txval_o) begin
         $display("timed out after %0d cycles waiting for txval_o to rise", TIMEOUT);
         errors++;
      end
   endtask

   // ====================
   // controller side
   task automatic send_setup(input req_code_e req, input logic [15:0] len);
      logic [7:0] b [8];
      b[0] = (req == SET_CUR) ? 8'h21 : 8'ha1;   // class request to interface
      b[1] = req;
      b[2] = 8'h00;
      b[3] = 8'(`UVC_VS_PROBE_CONTROL);
      b[4] = 8'(`UVC_VS_INTERFACE);
      b[5] = 8'h00;
      b[6] = len[7:0];
      b[7] = len[15:8];
      setup_i = 1'b1;
      for (int i = 0; i < 8; i++) begin
         rxdat_i = b[i];
         rxval_i = 1'b1;
         @(negedge PHY_CLKOUT);
         rxval_i = 1'b0;
         @(negedge PHY_CLKOUT);
      end
      setup_i = 1'b0;
   endtask

   // set_cur data stage with random bytes
   task automatic send_probe_data();
      logic [7:0] b;
      rxact_i = 1'b1;
      for (int i = 0; i < PLEN; i++) begin
         b   = rnd[7:0];
         rnd = xorshift32(rnd);
         if (i < 22 || i > 25) begin
            exp_probe[i] = b;              // payload size bytes stay put
         end
         rxdat_i = b;
         rxval_i = 1'b1;
         @(negedge PHY_CLKOUT);
         rxval_i = 1'b0;
         @(negedge PHY_CLKOUT);
      end
      rxact_i = 1'b0;
      @(negedge PHY_CLKOUT);
   endtask

   task automatic read_probe();
      wait_txval();
      txact_i = 1'b1;
      @(negedge PHY_CLKOUT);
      for (int k = 0; k < PLEN; k++) begin
         check_value($sformatf("probe byte %0d", k), txdat_o, exp_probe[k]);
         check_value("txval_o during read", txval_o, 1);
         txpop_i = 1'b1;
         @(negedge PHY_CLKOUT);
         txpop_i = 1'b0;
      end
      check_value("txval_o after last pop", txval_o, 0);
      txact_i = 1'b0;
      @(negedge PHY_CLKOUT);
   endtask

   task automatic fill_fifo(input int level);
      while (wr_count < level) begin
         frame_data_i = fill_byte(wr_count);
         frame_dval_i = 1'b1;
         @(negedge PHY_CLKOUT);
         wr_count++;
      end
      frame_dval_i = 1'b0;
   endtask

   // one iso transfer popping n bytes in write order
   task automatic iso_transfer(input int n);
      txact_i = 1'b1;
      for (int i = 0; i < n; i++) begin
         txpop_i = 1'b1;
         @(negedge PHY_CLKOUT);
         check_value($sformatf("iso byte %0d", rd_count), txdat_o, fill_byte(rd_count));
         rd_count++;
      end
      txpop_i = 1'b0;
      txact_i = 1'b0;
      @(negedge PHY_CLKOUT);
   endtask

   task automatic pulse_sof();
      sof_i = 1'b1;
      @(negedge PHY_CLKOUT);
      sof_i = 1'b0;
   endtask

   task automatic set_alt(input logic [7:0] sel, input logic [7:0] val);
      inf_sel_i   = sel;
      inf_alter_i = val;
      inf_set_i   = 1'b1;
      @(negedge PHY_CLKOUT);
      inf_set_i   = 1'b0;
   endtask

   // ====================
   // test sequence
   initial begin
      RESET_IN     = 1'b1;
      setup_i      = 1'b0;
      endpt_i      = '0;
      rxdat_i      = '0;
      rxval_i      = 1'b0;
      rxact_i      = 1'b0;
      txact_i      = 1'b0;
      txpop_i      = 1'b0;
      sof_i        = 1'b0;
      inf_sel_i    = '0;
      inf_alter_i  = '0;
      inf_set_i    = 1'b0;
      frame_data_i = '0;
      frame_dval_i = 1'b0;
      errors       = 0;
      checks       = 0;
      wr_count     = 0;
      rd_count     = 0;
      rnd          = 32'hdcc7_2d11;

      repeat (8) @(negedge PHY_CLKOUT);
      RESET_IN = 1'b0;
      @(negedge PHY_CLKOUT);

      check_value("txval_o after reset", txval_o, 0);
      check_value("txcork_o after reset", txcork_o, 0);
      check_value("txdat_len_o after reset", 32'(txdat_len_o), `UVC_PROBE_LEN);
      check_value("txiso_pid_o after reset", txiso_pid_o, PID_DATA2);
      check_value("inf_alter_o after reset", inf_alter_o, 0);

      // default probe block with little endian fields
      for (int i = 0; i < PLEN; i++) begin
         exp_probe[i] = 8'h00;
      end
      exp_probe[2] = 8'd1;
      exp_probe[3] = 8'd1;
      put_le32(4, `UVC_DEF_FRAME_INTERVAL);
      put_le32(18, `UVC_DEF_MAX_FRAME_SIZE);
      put_le32(22, `UVC_PAYLOAD_SIZE);
      put_le32(26, `UVC_DEF_CLOCK_FREQ);
      send_setup(GET_CUR, 16'(PLEN));
      read_probe();

      send_setup(SET_CUR, 16'(PLEN));
      repeat (2) @(negedge PHY_CLKOUT);
      send_probe_data();
      send_setup(GET_CUR, 16'(PLEN));
      read_probe();

      for (int r = 0; r < 8; r++) begin
         endpt_i = endpt_t'(size_tab[r].endpt);
         fill_fifo(size_tab[r].level);
         @(negedge PHY_CLKOUT);
         check_value($sformatf("txdat_len_o row %0d", r), 32'(txdat_len_o), size_tab[r].len);
         check_value($sformatf("txcork_o row %0d", r), txcork_o, size_tab[r].cork);
      end

      // each sof below moves the pid away from its previous value
      endpt_i = endpt_t'(`UVC_ISO_ENDPT);
      @(negedge PHY_CLKOUT);
      iso_transfer(wr_count - rd_count - 300);   // down to almost empty
      pulse_sof();
      check_value("pid after sof, almost empty", txiso_pid_o, PID_DATA0);
      fill_fifo(wr_count + 400);                 // level between thresholds
      pulse_sof();
      check_value("pid after sof, mid level", txiso_pid_o, PID_DATA1);
      fill_fifo(wr_count + 500);                 // almost full
      pulse_sof();
      check_value("pid after sof, almost full", txiso_pid_o, PID_DATA2);
      iso_transfer(4);
      check_value("pid after 1st transfer", txiso_pid_o, PID_DATA1);
      iso_transfer(4);
      check_value("pid after 2nd transfer", txiso_pid_o, PID_DATA0);
      iso_transfer(4);
      check_value("pid after 3rd transfer", txiso_pid_o, PID_DATA0);

      set_alt(8'd0, 8'd3);
      set_alt(8'd1, 8'd5);
      set_alt(8'd2, 8'd7);                       // no such interface
      for (int s = 0; s < 3; s++) begin
         inf_sel_i = 8'(s);
         @(negedge PHY_CLKOUT);
         check_value($sformatf("alt setting %0d", s), inf_alter_o,
                     (s == 0) ? 3 : (s == 1) ? 5 : 0);
      end

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: verilog.f
+incdir+src
src/usb_pkg.sv
src/uvc_pkg.sv
src/ctrl_if.sv
src/setup_parser.sv
src/video_ctrl_regs.sv
src/endpoint_router.sv
src/iso_payload_ctrl.sv
src/frame_fifo.sv
src/uvc_app_top.sv
sim/tb_uvc_app.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the uvc testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_uvc_app -f verilog.f
if [ $? -ne 0 ]; then
   echo "verilator compile failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_uvc_app)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "PASS: all tests"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
